/* common/ttc_pkg.sv */
// Timer package with widths, register map, control bits and bus structs
`default_nettype none

package ttc_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int ttc_cw = 16;                  // Counter and compare width
  localparam int ttc_iw = 6;                   // Interrupt register width

  // ----------------------------------------
  // Register map, byte addresses
  // ----------------------------------------
  localparam logic [7:0] addr_ctrl     = 8'h00; // Counter control
  localparam logic [7:0] addr_interval = 8'h04; // Interval wrap value
  localparam logic [7:0] addr_match1   = 8'h08; // Match 1 compare
  localparam logic [7:0] addr_match2   = 8'h0C; // Match 2 compare
  localparam logic [7:0] addr_match3   = 8'h10; // Match 3 compare
  localparam logic [7:0] addr_count    = 8'h14; // Counter value, read only
  localparam logic [7:0] addr_int      = 8'h18; // Interrupt status, clear on read
  localparam logic [7:0] addr_int_en   = 8'h1C; // Interrupt enable mask

  // Control register bit positions
  localparam int ctrl_dis_bit   = 0;           // Stop counter
  localparam int ctrl_intv_bit  = 1;           // Wrap at interval
  localparam int ctrl_match_bit = 2;           // Match compares on
  localparam int ctrl_rst_bit   = 4;           // Restart, never stored

  // ----------------------------------------
  // Structs
  // ----------------------------------------

  // Counter set-up, held in the register block
  typedef struct packed {
    logic              cnt_en;                 // Counter running
    logic              intv_mode;              // Interval mode
    logic              match_en;               // Match events enabled
    logic [ttc_cw-1:0] interval;               // Interval wrap value
    logic [ttc_cw-1:0] match1;
    logic [ttc_cw-1:0] match2;
    logic [ttc_cw-1:0] match3;
  } ttc_cfg_t;

  // One-cycle event pulses out of the counter
  typedef struct packed {
    logic       interval;                      // Interval reached
    logic [3:1] match;                         // Match n hit
    logic       overflow;                      // Wrapped past all ones
  } ttc_evt_t;

endpackage

`default_nettype wire

/* src/ttc_count.sv */
// Counter with interval wrap, three match compares and overflow events
`timescale 1ns/10ps
`default_nettype none

module ttc_count (
  input  logic                      pclk2,
  input  logic                      n_p_reset2,
  input  ttc_pkg::ttc_cfg_t         cfg,      // Mode, interval and match values
  input  logic                      restart,  // Zero the count at next edge
  output logic [ttc_pkg::ttc_cw-1:0] count,   // Current value, for readback
  output ttc_pkg::ttc_evt_t         evt       // Registered event pulses
);

  import ttc_pkg::*;

  logic       intv_hit;                       // Count sits on the interval
  logic       ovf_hit;                        // Count sits on all ones
  logic [3:1] match_hit;                      // Per-channel compare result
  logic       advance;                        // Counter steps this cycle

  // ----------------------------------------
  // Compare logic
  // ----------------------------------------

  // Interval only counts in interval mode
  assign intv_hit = cfg.intv_mode & (count == cfg.interval);

  // Natural wrap, unless the interval already took it
  assign ovf_hit  = ~intv_hit & (&count);

  always_comb
  begin
    match_hit[1] = (count == cfg.match1);
    match_hit[2] = (count == cfg.match2);
    match_hit[3] = (count == cfg.match3);
  end

  // A restart cycle wins over counting
  assign advance = cfg.cnt_en & ~restart;

  // ----------------------------------------
  // Counter register
  // ----------------------------------------
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
    begin
      count <= '0;
    end
    else if (restart)
    begin
      count <= '0;                            // Software restart
    end
    else if (cfg.cnt_en)
    begin
      if (intv_hit)
      begin
        count <= '0;                          // Interval wrap
      end
      else
      begin
        count <= count + ttc_cw'(1);          // Also wraps at all ones
      end
    end
  end

  // ----------------------------------------
  // Event pulses
  // ----------------------------------------

  // Events only while the counter moves, so a stopped counter
  // parked on a compare value cannot repeat a pulse
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
    begin
      evt <= '0;
    end
    else
    begin
      evt.interval <= advance & intv_hit;
      evt.overflow <= advance & ovf_hit;
      evt.match    <= match_hit & {3{advance & cfg.match_en}};
    end
  end

endmodule

`default_nettype wire

/* src/ttc_interrupt.sv */
// Interrupt edge capture, enable mask, status register with read clear
`timescale 1ns/10ps
`default_nettype none

module ttc_interrupt (
  input  logic                      pclk2,
  input  logic                      n_p_reset2,
  input  ttc_pkg::ttc_evt_t         evt,          // Pulses from the counter
  input  logic                      int_en_wr,    // Enable register write strobe
  input  logic [ttc_pkg::ttc_iw-1:0] int_en_data, // New enable mask
  input  logic                      int_rd,       // Status read strobe
  output logic [ttc_pkg::ttc_iw-1:0] int_reg,     // Interrupt status
  output logic [ttc_pkg::ttc_iw-1:0] int_en,      // Interrupt enable mask
  output logic                      interrupt     // Combined interrupt line
);

  import ttc_pkg::*;

  logic [ttc_iw-1:0] int_detect;              // Events in register layout
  logic [ttc_iw-1:0] int_sync;                // First stage, events as sampled
  logic [ttc_iw-1:0] int_sync_d;              // Previous sample
  logic [ttc_iw-1:0] int_edge;                // Rising edges only
  logic              interrupt_set;           // Edge was pending last cycle
  logic [ttc_iw-1:0] new_int;                 // Enabled new edges

  // Bit 5 spare, bit 4 overflow, bits 3..1 match, bit 0 interval
  assign int_detect = {1'b0, evt.overflow, evt.match, evt.interval};

  assign new_int = int_edge & int_en;

  // ----------------------------------------
  // Edge capture
  // ----------------------------------------
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
    begin
      int_sync      <= '0;
      int_sync_d    <= '0;
      int_edge      <= '0;
      interrupt_set <= 1'b0;
    end
    else
    begin
      int_sync      <= int_detect;
      int_sync_d    <= int_sync;
      int_edge      <= int_sync & ~int_sync_d;  // Held event seen once
      interrupt_set <= |int_edge;               // Guards against lost edges
    end
  end

  // ----------------------------------------
  // Status and enable registers
  // ----------------------------------------
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
    begin
      int_reg <= '0;
    end
    else if (int_rd & ~interrupt_set)
    begin
      int_reg <= new_int;                     // Read clears, keep fresh edges
    end
    else
    begin
      int_reg <= int_reg | new_int;           // Accumulate until read
    end
  end

  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
      int_en <= '0;
    else if (int_en_wr)
      int_en <= int_en_data;                  // Loads at the access edge
  end

  // Any pending status bit raises the line
  assign interrupt = |int_reg;

endmodule

`default_nettype wire

/* src/ttc_apb_regs.sv */
// APB2 register decode, timer configuration, read mux and restart pulse
`timescale 1ns/10ps
`default_nettype none

module ttc_apb_regs (
  input  logic                       pclk2,
  input  logic                       n_p_reset2,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  input  logic [ttc_pkg::ttc_cw-1:0] count,       // Counter value for readback
  input  logic [ttc_pkg::ttc_iw-1:0] int_reg,     // Interrupt status
  input  logic [ttc_pkg::ttc_iw-1:0] int_en,      // Interrupt enable mask
  output ttc_pkg::ttc_cfg_t          cfg,         // Counter set-up
  output logic                       restart,     // One-cycle counter restart
  output logic                       int_en_wr,   // Enable mask write strobe
  output logic                       int_rd,      // Status read strobe
  output logic [ttc_pkg::ttc_iw-1:0] int_en_data  // Enable mask write data
);

  import ttc_pkg::*;

  logic access;                               // APB access phase
  logic wr_en;
  logic rd_en;
  logic ctrl_wr;                              // Control register write

  // ----------------------------------------
  // Access decode
  // ----------------------------------------
  assign access  = psel & penable;
  assign wr_en   = access & pwrite;
  assign rd_en   = access & ~pwrite;
  assign ctrl_wr = wr_en & (paddr == addr_ctrl);

  // Strobes for the interrupt block, valid in the access cycle
  assign int_en_wr   = wr_en & (paddr == addr_int_en);
  assign int_rd      = rd_en & (paddr == addr_int);
  assign int_en_data = pwdata[ttc_iw-1:0];

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------

  // All zero out of reset, so the counter starts stopped
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
    begin
      cfg <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        addr_ctrl:
        begin
          cfg.cnt_en    <= ~pwdata[ctrl_dis_bit]; // Stored as run enable
          cfg.intv_mode <= pwdata[ctrl_intv_bit];
          cfg.match_en  <= pwdata[ctrl_match_bit];
        end
        addr_interval: cfg.interval <= pwdata[ttc_cw-1:0];
        addr_match1:   cfg.match1   <= pwdata[ttc_cw-1:0];
        addr_match2:   cfg.match2   <= pwdata[ttc_cw-1:0];
        addr_match3:   cfg.match3   <= pwdata[ttc_cw-1:0];
        default:       ;              // Read-only or unmapped
      endcase
    end
  end

  // Restart bit becomes a pulse the cycle after the write
  always_ff @(posedge pclk2 or negedge n_p_reset2)
  begin
    if (!n_p_reset2)
      restart <= 1'b0;
    else
      restart <= ctrl_wr & pwdata[ctrl_rst_bit];
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb
  begin
    prdata = '0;                              // Idle bus reads zero
    if (rd_en)
    begin
      case (paddr)
        addr_ctrl:
        begin
          prdata[ctrl_dis_bit]   = ~cfg.cnt_en;
          prdata[ctrl_intv_bit]  = cfg.intv_mode;
          prdata[ctrl_match_bit] = cfg.match_en;
        end
        addr_interval: prdata[ttc_cw-1:0] = cfg.interval;
        addr_match1:   prdata[ttc_cw-1:0] = cfg.match1;
        addr_match2:   prdata[ttc_cw-1:0] = cfg.match2;
        addr_match3:   prdata[ttc_cw-1:0] = cfg.match3;
        addr_count:    prdata[ttc_cw-1:0] = count;
        addr_int:      prdata[ttc_iw-1:0] = int_reg;  // Cleared by int_rd
        addr_int_en:   prdata[ttc_iw-1:0] = int_en;
        default:       ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/ttc_timer_top.sv */
// Timer top level joining register block, counter and interrupt block
`timescale 1ns/10ps
`default_nettype none

module ttc_timer_top (
  input  logic        pclk2,
  input  logic        n_p_reset2,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        interrupt
);

  import ttc_pkg::*;

  ttc_cfg_t          cfg;                     // Registers to counter
  logic              restart;
  logic [ttc_cw-1:0] count;                   // Counter back to registers
  ttc_evt_t          evt;                     // Counter to interrupt block
  logic              int_en_wr;
  logic              int_rd;
  logic [ttc_iw-1:0] int_en_data;
  logic [ttc_iw-1:0] int_reg;
  logic [ttc_iw-1:0] int_en;

  ttc_apb_regs u_regs (
    .pclk2       (pclk2),
    .n_p_reset2  (n_p_reset2),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .count       (count),
    .int_reg     (int_reg),
    .int_en      (int_en),
    .cfg         (cfg),
    .restart     (restart),
    .int_en_wr   (int_en_wr),
    .int_rd      (int_rd),
    .int_en_data (int_en_data)
  );

  ttc_count u_count (
    .pclk2      (pclk2),
    .n_p_reset2 (n_p_reset2),
    .cfg        (cfg),
    .restart    (restart),
    .count      (count),
    .evt        (evt)
  );

  ttc_interrupt u_int (
    .pclk2       (pclk2),
    .n_p_reset2  (n_p_reset2),
    .evt         (evt),
    .int_en_wr   (int_en_wr),
    .int_en_data (int_en_data),
    .int_rd      (int_rd),
    .int_reg     (int_reg),
    .int_en      (int_en),
    .interrupt   (interrupt)
  );

endmodule

`default_nettype wire

/* tb/ttc_timer_assert.sv */
// Concurrent assertions on the interrupt block and its bind statement
`timescale 1ns/10ps
`default_nettype none

module ttc_timer_assert (
  input logic                       pclk2,
  input logic                       n_p_reset2,
  input ttc_pkg::ttc_evt_t          evt,           // Counter event pulses
  input logic                       int_rd,
  input logic                       interrupt_set, // Edge pending last cycle
  input logic [ttc_pkg::ttc_iw-1:0] new_int,       // Enabled edges this cycle
  input logic [ttc_pkg::ttc_iw-1:0] int_reg,
  input logic                       interrupt
);

  import ttc_pkg::*;

  logic [4:0] evt_bits;                       // Flat view of the pulses

  assign evt_bits = evt;

  // ----------------------------------------
  // Properties
  // ----------------------------------------

  // Pulses last one cycle
  evt_single: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
    (evt_bits & $past(evt_bits)) == 5'd0)
    else $error("evt bit high for two cycles");

  // Pending line only drops through a status read
  irq_fall: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
    $fell(interrupt) |-> $past(int_rd))
    else $error("interrupt dropped without a status read");

  // Clearing read keeps only fresh enabled edges
  read_clear: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
    (int_rd && !interrupt_set) |=> (int_reg == $past(new_int)))
    else $error("int_reg not cleared by read");

endmodule

bind ttc_interrupt ttc_timer_assert u_assert (
  .pclk2         (pclk2),
  .n_p_reset2    (n_p_reset2),
  .evt           (evt),
  .int_rd        (int_rd),
  .interrupt_set (interrupt_set),
  .new_int       (new_int),
  .int_reg       (int_reg),
  .interrupt     (interrupt)
);

`default_nettype wire

/* tb/ttc_timer_tb.sv */
// Timer testbench with APB tasks, reference model, result checker and watchdog
`timescale 1ns/10ps
`default_nettype none

module ttc_timer_tb;

  import ttc_pkg::*;

  localparam int num_tests    = 5;
  localparam int max_interval = 65536;        // Longest pass is a free-running wrap
  localparam int watchdog_cyc = num_tests * (max_interval + 200);

  // Control words
  localparam logic [31:0] c_dis   = 32'd1 << ctrl_dis_bit;
  localparam logic [31:0] c_intv  = 32'd1 << ctrl_intv_bit;
  localparam logic [31:0] c_match = 32'd1 << ctrl_match_bit;
  localparam logic [31:0] c_rst   = 32'd1 << ctrl_rst_bit;

  logic        pclk2;
  logic        n_p_reset2;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        interrupt;

  int          errors;
  int          checks;
  string       name_q[$];                     // Results waiting for the checker
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];

  ttc_timer_top UUT (
    .pclk2      (pclk2),
    .n_p_reset2 (n_p_reset2),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .interrupt  (interrupt)
  );

  always #20 pclk2 = ~pclk2;                  // 40 ns period

  // ----------------------------------------
  // Bus and timing tasks
  // ----------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge pclk2);
    #2;
    psel    = 1'b1;                           // Setup phase
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk2);
    #2;
    penable = 1'b1;                           // Access phase
    @(posedge pclk2);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge pclk2);
    #2;
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk2);
    #2;
    penable = 1'b1;
    @(negedge pclk2);
    data    = prdata;                         // Mid access cycle, settled
    @(posedge pclk2);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge pclk2);
  endtask

  // Polled at the falling edge, away from register updates
  task automatic wait_interrupt();
    @(negedge pclk2);
    while (!interrupt)
      @(negedge pclk2);
  endtask

  // ----------------------------------------
  // Reference model and checking
  // ----------------------------------------

  // Interrupt bits left by one full counting pass
  function automatic logic [31:0] expected_int(input logic [5:0] en_mask,
                                               input logic intv_mode,
                                               input logic [15:0] interval,
                                               input logic [15:0] m1,
                                               input logic [15:0] m2,
                                               input logic [15:0] m3,
                                               input logic match_en);
    logic [5:0]  bits;
    logic [15:0] top;                         // Last value of the pass
    bits = '0;
    top  = intv_mode ? interval : 16'hFFFF;
    if (intv_mode)
      bits[0] = 1'b1;                         // Interval wrap
    else
      bits[4] = 1'b1;                         // Natural overflow
    if (match_en)
    begin
      bits[1] = (m1 <= top);                  // Reached only inside the pass
      bits[2] = (m2 <= top);
      bits[3] = (m3 <= top);
    end
    return {26'd0, bits & en_mask};
  endfunction

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // Compare process, drains results each clock
  always @(posedge pclk2)
  begin
    while (got_q.size() > 0)
      check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
  end

  // Random register write and readback
  task automatic readback(input logic [7:0] addr, input string name,
                          input logic [31:0] mask);
    logic [31:0] wval;
    logic [31:0] rd;
    wval = $urandom;
    apb_write(addr, wval);
    apb_read(addr, rd);
    expect_value(name, rd, wval & mask);
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial
  begin
    repeat (watchdog_cyc) @(posedge pclk2);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cyc);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  initial
  begin : stimulus
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [15:0] interval;
    logic [15:0] m1;
    logic [15:0] m2;
    logic [15:0] m3;
    int          seed;
    pclk2      = 1'b0;
    n_p_reset2 = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    errors     = 0;
    checks     = 0;
    seed       = $urandom(84);                // Fixed seed for the run
    repeat (10) @(posedge pclk2);
    #2 n_p_reset2 = 1'b1;

    // 1. Register readback, counter stopped out of reset
    apb_read(addr_int, rd);
    expect_value("int after reset", rd, 32'h0);
    readback(addr_interval, "interval", 32'h0000FFFF);
    readback(addr_match1, "match1", 32'h0000FFFF);
    readback(addr_match2, "match2", 32'h0000FFFF);
    readback(addr_match3, "match3", 32'h0000FFFF);
    readback(addr_int_en, "int_en", 32'h0000003F);
    apb_read(addr_count, rd);
    expect_value("count while disabled", rd, 32'h0);

    // 2. Interval mode, some matches beyond the interval
    interval = 16'(8 + $urandom % 24);
    m1 = 16'($urandom % (32'(interval) + 8));
    m2 = 16'($urandom % (32'(interval) + 8));
    m3 = 16'($urandom % (32'(interval) + 8));
    apb_write(addr_interval, 32'(interval));
    apb_write(addr_match1, 32'(m1));
    apb_write(addr_match2, 32'(m2));
    apb_write(addr_match3, 32'(m3));
    apb_write(addr_int_en, 32'h3F);
    apb_write(addr_ctrl, c_intv | c_match | c_rst);
    wait_interrupt();
    idle_cycles(32'(interval) + 12);          // Cover a whole pass
    apb_write(addr_ctrl, c_dis);
    idle_cycles(8);                           // Let pending edges land
    apb_read(addr_int, rd);
    expect_value("int interval pass", rd, expected_int(6'h3F, 1'b1, interval, m1, m2, m3, 1'b1));
    apb_read(addr_int, rd);
    expect_value("int second read", rd, 32'h0);

    // 3. Interval bit masked, matches off
    apb_write(addr_int_en, 32'h3E);
    apb_write(addr_ctrl, c_intv | c_rst);
    idle_cycles(32'(interval) + 12);
    @(negedge pclk2);                         // Sample the line between edges
    expect_value("interrupt masked", 32'(interrupt), 32'h0);
    apb_write(addr_ctrl, c_dis);
    idle_cycles(8);
    apb_read(addr_int, rd);
    expect_value("int masked", rd, expected_int(6'h3E, 1'b1, interval, m1, m2, m3, 1'b0));

    // 4. Restart, then disable holds the count
    apb_write(addr_ctrl, 32'h0);              // Free running
    idle_cycles(60);
    apb_write(addr_ctrl, c_rst);
    apb_read(addr_count, rd);
    expect_value("count below bound", 32'(rd < 32'd16), 32'h1);
    apb_write(addr_ctrl, c_dis);
    idle_cycles(2);
    apb_read(addr_count, rd);
    idle_cycles(10);
    apb_read(addr_count, rd2);
    expect_value("count held", rd2, rd);

    // 5. Overflow mode, run close to the wrap with interrupts off
    apb_write(addr_int_en, 32'h0);
    apb_write(addr_ctrl, c_rst);
    rd = '0;
    while (rd < 32'h0000FF00)
      apb_read(addr_count, rd);
    apb_write(addr_int_en, 32'h3F);
    wait_interrupt();
    apb_write(addr_ctrl, c_dis);
    idle_cycles(8);
    apb_read(addr_int, rd);
    expect_value("int overflow pass", rd, expected_int(6'h3F, 1'b0, interval, m1, m2, m3, 1'b0));

    idle_cycles(4);                           // Checker drains the queue
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
common/ttc_pkg.sv
src/ttc_count.sv
src/ttc_interrupt.sv
src/ttc_apb_regs.sv
src/ttc_timer_top.sv
tb/ttc_timer_assert.sv
tb/ttc_timer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ttc_timer_tb \
  -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vttc_timer_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
